// ==== include/fu_settings.svh ====
`ifndef FU_SETTINGS_SVH
`define FU_SETTINGS_SVH

// lanes per vector, also the side of the square PE grid
`define FU_SYSTOLIC_SIZE 4

// width of one feature, weight or partial sum value
`define FU_DATA_WIDTH 16

// FIFO depth per lane and the longest dot product a run may ask for
`define FU_MAX_STEPS 16

// wide enough to hold FU_MAX_STEPS itself
`define FU_STEP_W 5

`endif

// ==== src/fifo_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

// one instance feeds both the ifm and the wgt FIFO arrays
interface fifo_ctrl_if;

	logic                         wr_clr;
	logic                         wr_en;
	logic                         rd_clr;
	logic [`FU_SYSTOLIC_SIZE-1:0] rd_en;

	modport ctrl (
		output wr_clr,
		output wr_en,
		output rd_clr,
		output rd_en
	);

	modport fifo (
		input wr_clr,
		input wr_en,
		input rd_clr,
		input rd_en
	);

endinterface

`default_nettype wire

// ==== src/fu_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module fu_controller import fu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic [`FU_STEP_W-1:0] num_steps,
	input  logic                  in_valid,
	fifo_ctrl_if.ctrl             fifo_ctl,
	output logic                  reset_pe,
	output logic                  write_out_en,
	output logic                  row_first,
	output logic                  done,
	output logic                  busy
);

	localparam int N      = `FU_SYSTOLIC_SIZE;
	localparam int SKEW_W = `FU_STEP_W + 1;
	localparam int ROW_W  = $clog2(N);

	fu_state_e state_q;
	fu_state_e state_d;

	logic [`FU_STEP_W-1:0] steps_q;
	logic [`FU_STEP_W-1:0] step_cnt;
	logic [SKEW_W-1:0]     skew_cnt;
	logic [SKEW_W-1:0]     skew_last;
	logic [ROW_W-1:0]      row_cnt;
	logic                  load_first;
	logic                  compute_first;

	// the far corner PE sees its last product at cycle steps + 2N - 2
	assign skew_last = {1'b0, steps_q} + SKEW_W'(2 * N - 1);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start) begin
					state_d = LOAD;
				end
			end
			LOAD: begin
				if (in_valid && step_cnt == steps_q - 1'b1) begin
					state_d = COMPUTE;
				end
			end
			COMPUTE: begin
				if (skew_cnt == skew_last) begin
					state_d = DRAIN;
				end
			end
			DRAIN: begin
				if (row_cnt == ROW_W'(N - 1)) begin
					state_d = FINISH;
				end
			end
			FINISH: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q       <= IDLE;
			step_cnt      <= '0;
			skew_cnt      <= '0;
			row_cnt       <= '0;
			load_first    <= 1'b0;
			compute_first <= 1'b0;
		end else begin
			state_q       <= state_d;
			step_cnt      <= (state_q == LOAD) ? step_cnt + in_valid : '0;
			skew_cnt      <= (state_q == COMPUTE) ? skew_cnt + 1'b1 : '0;
			row_cnt       <= (state_q == DRAIN) ? row_cnt + 1'b1 : '0;
			load_first    <= (state_q == IDLE) && start;
			compute_first <= (state_q == LOAD) && (state_d == COMPUTE);
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == IDLE && start) begin
			steps_q <= num_steps;
		end
	end

	assign fifo_ctl.wr_clr = load_first;
	assign fifo_ctl.wr_en  = (state_q == LOAD) && in_valid;
	assign fifo_ctl.rd_clr = compute_first;

	// lane i starts i cycles late, which lines the operands up in the grid
	for (genvar i = 0; i < N; i++) begin : g_rd_en
		assign fifo_ctl.rd_en[i] = (state_q == COMPUTE)
			&& (skew_cnt >= SKEW_W'(i))
			&& (skew_cnt < SKEW_W'(i) + {1'b0, steps_q});
	end

	assign reset_pe     = compute_first;
	assign write_out_en = (state_q == DRAIN);
	assign row_first    = (state_q == DRAIN) && (row_cnt == '0);
	assign done         = (state_q == FINISH);
	assign busy         = (state_q != IDLE);

	a_steps_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q == IDLE && start) |-> (num_steps != '0 && num_steps <= `FU_MAX_STEPS));

	// done comes right after the last drain row and lasts a single cycle
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(write_out_en) |-> ##N (done && !write_out_en) ##1 !done);

endmodule

`default_nettype wire

// ==== src/fu_pkg.sv ====
`default_nettype none

`include "fu_settings.svh"

package fu_pkg;

	// one signed lane, partial sums wrap at this width
	typedef logic signed [`FU_DATA_WIDTH-1:0] lane_t;

	// lane 0 sits in the low bits
	typedef lane_t [`FU_SYSTOLIC_SIZE-1:0] vec_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		COMPUTE,
		DRAIN,
		FINISH
	} fu_state_e;

endpackage

`default_nettype wire

// ==== src/functional_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module functional_unit import fu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic [`FU_STEP_W-1:0] num_steps,
	input  logic                  maxpool_mode,
	input  logic                  in_valid,
	input  vec_t                  ifm_data,
	input  vec_t                  wgt_data,
	output logic                  done,
	output logic                  busy,
	output logic                  ofm_valid,
	output vec_t                  ofm_data
);

	vec_t ifm_lanes;
	vec_t wgt_lanes;
	vec_t ofm_row;
	logic reset_pe;
	logic write_out_en;
	logic row_first;

	fifo_ctrl_if fifo_ctl ();

	fu_controller control (
		.clk          ( clk          ),
		.rst_n        ( rst_n        ),
		.start        ( start        ),
		.num_steps    ( num_steps    ),
		.in_valid     ( in_valid     ),
		.fifo_ctl     ( fifo_ctl     ),
		.reset_pe     ( reset_pe     ),
		.write_out_en ( write_out_en ),
		.row_first    ( row_first    ),
		.done         ( done         ),
		.busy         ( busy         )
	);

	// feature rows enter from the left edge of the grid
	skew_fifo_array ifm_fifo_array (
		.clk      ( clk       ),
		.rst_n    ( rst_n     ),
		.data_in  ( ifm_data  ),
		.ctl      ( fifo_ctl  ),
		.data_out ( ifm_lanes )
	);

	// weight columns enter from the top edge
	skew_fifo_array wgt_fifo_array (
		.clk      ( clk       ),
		.rst_n    ( rst_n     ),
		.data_in  ( wgt_data  ),
		.ctl      ( fifo_ctl  ),
		.data_out ( wgt_lanes )
	);

	pe_array pe_grid (
		.clk          ( clk          ),
		.rst_n        ( rst_n        ),
		.reset_pe     ( reset_pe     ),
		.write_out_en ( write_out_en ),
		.ifm_in       ( ifm_lanes    ),
		.wgt_in       ( wgt_lanes    ),
		.ofm_row      ( ofm_row      )
	);

	ofm_output_stage ofm_stage (
		.clk          ( clk          ),
		.rst_n        ( rst_n        ),
		.write_out_en ( write_out_en ),
		.row_first    ( row_first    ),
		.maxpool_mode ( maxpool_mode ),
		.ofm_row      ( ofm_row      ),
		.ofm_valid    ( ofm_valid    ),
		.ofm_data     ( ofm_data     )
	);

endmodule

`default_nettype wire

// ==== src/ofm_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module ofm_output_stage import fu_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic write_out_en,
	input  logic row_first,
	input  logic maxpool_mode,
	input  vec_t ofm_row,
	output logic ofm_valid,
	output vec_t ofm_data
);

	localparam int N = `FU_SYSTOLIC_SIZE;

	logic odd_q;
	logic row_odd;
	vec_t row_buf;
	vec_t vert_max;
	vec_t pooled;
	vec_t selected;

	function automatic lane_t lane_max(lane_t a, lane_t b);
		return (a > b) ? a : b;
	endfunction

	function automatic lane_t relu(lane_t x);
		return (x < 0) ? lane_t'(0) : x;
	endfunction

	// row parity restarts at every drain so runs stay independent
	assign row_odd = row_first ? 1'b0 : odd_q;

	always_comb begin
		pooled = '0;
		for (int i = 0; i < N; i++) begin
			vert_max[i] = lane_max(row_buf[i], ofm_row[i]);
		end
		// lanes 2j and 2j+1 collapse into lane j, upper half stays zero
		for (int j = 0; j < N / 2; j++) begin
			pooled[j] = lane_max(vert_max[2*j], vert_max[2*j+1]);
		end
	end

	assign selected = maxpool_mode ? pooled : ofm_row;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			odd_q     <= 1'b0;
			ofm_valid <= 1'b0;
		end else begin
			ofm_valid <= write_out_en && (!maxpool_mode || row_odd);
			if (write_out_en) begin
				odd_q <= !row_odd;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (write_out_en && !row_odd) begin
			row_buf <= ofm_row;
		end
		if (write_out_en) begin
			for (int i = 0; i < N; i++) begin
				ofm_data[i] <= relu(selected[i]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/pe_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module pe_array import fu_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic reset_pe,
	input  logic write_out_en,
	input  vec_t ifm_in,
	input  vec_t wgt_in,
	output vec_t ofm_row
);

	localparam int N = `FU_SYSTOLIC_SIZE;

	// operand pipeline registers, ifm moves right and wgt moves down
	lane_t a_q [N][N];
	lane_t b_q [N][N];
	// output stationary accumulators
	lane_t acc [N][N];

	for (genvar r = 0; r < N; r++) begin : g_row
		for (genvar c = 0; c < N; c++) begin : g_col
			lane_t a_in;
			lane_t b_in;
			lane_t below;

			if (c == 0) begin : g_left_edge
				assign a_in = ifm_in[r];
			end else begin : g_from_left
				assign a_in = a_q[r][c-1];
			end

			if (r == 0) begin : g_top_edge
				assign b_in = wgt_in[c];
			end else begin : g_from_above
				assign b_in = b_q[r-1][c];
			end

			// the bottom row refills with zeros while the grid drains
			if (r == N - 1) begin : g_last_row
				assign below = '0;
			end else begin : g_inner_row
				assign below = acc[r+1][c];
			end

			always_ff @(posedge clk) begin
				if (!rst_n) begin
					a_q[r][c] <= '0;
					b_q[r][c] <= '0;
					acc[r][c] <= '0;
				end else begin
					a_q[r][c] <= a_in;
					b_q[r][c] <= b_in;
					if (reset_pe) begin
						acc[r][c] <= '0;
					end else if (write_out_en) begin
						acc[r][c] <= below;
					end else begin
						// product truncated to lane width, sum wraps mod 2^16
						acc[r][c] <= acc[r][c] + lane_t'(a_in * b_in);
					end
				end
			end
		end
	end

	for (genvar c = 0; c < N; c++) begin : g_out
		assign ofm_row[c] = write_out_en ? acc[0][c] : '0;
	end

endmodule

`default_nettype wire

// ==== src/skew_fifo_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module skew_fifo_array import fu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  vec_t      data_in,
	fifo_ctrl_if.fifo ctl,
	output vec_t      data_out
);

	localparam int N     = `FU_SYSTOLIC_SIZE;
	localparam int DEPTH = `FU_MAX_STEPS;
	localparam int AW    = $clog2(DEPTH);
	localparam int PW    = `FU_STEP_W;

	logic [PW-1:0] wr_ptr;
	logic [AW-1:0] wr_addr;

	// a clear pulse restarts at entry 0 even when it coincides with a write
	assign wr_addr = ctl.wr_clr ? '0 : wr_ptr[AW-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (ctl.wr_clr) begin
			wr_ptr <= PW'(ctl.wr_en);
		end else if (ctl.wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		(ctl.wr_en && !ctl.wr_clr) |-> (wr_ptr < DEPTH));

	for (genvar i = 0; i < N; i++) begin : g_lane
		lane_t         mem [DEPTH];
		logic [PW-1:0] rd_ptr;
		logic [AW-1:0] rd_addr;

		assign rd_addr = ctl.rd_clr ? '0 : rd_ptr[AW-1:0];

		always_ff @(posedge clk) begin
			if (ctl.wr_en) begin
				mem[wr_addr] <= data_in[i];
			end
		end

		// idle lanes present zero so the PE grid only ever sees real operands
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				rd_ptr      <= '0;
				data_out[i] <= '0;
			end else begin
				if (ctl.rd_clr) begin
					rd_ptr <= PW'(ctl.rd_en[i]);
				end else if (ctl.rd_en[i]) begin
					rd_ptr <= rd_ptr + 1'b1;
				end
				data_out[i] <= ctl.rd_en[i] ? mem[rd_addr] : '0;
			end
		end

		// the controller must never read a lane past what was loaded
		a_rd_in_range: assert property (@(posedge clk) disable iff (!rst_n)
			ctl.rd_en[i] |-> (ctl.rd_clr ? (wr_ptr != '0) : (rd_ptr < wr_ptr)));
	end

endmodule

`default_nettype wire

// ==== test/tb_functional_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module tb_functional_unit import fu_pkg::*; ();

	localparam int N       = `FU_SYSTOLIC_SIZE;
	localparam int MAX     = `FU_MAX_STEPS;
	localparam int TIMEOUT = 200;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  start;
	logic [`FU_STEP_W-1:0] num_steps;
	logic                  maxpool_mode;
	logic                  in_valid;
	vec_t                  ifm_data;
	vec_t                  wgt_data;
	logic                  done;
	logic                  busy;
	logic                  ofm_valid;
	vec_t                  ofm_data;

	int   seed = 1978;
	int   ifm_s [MAX][N];
	int   wgt_s [MAX][N];
	vec_t exp_q [$];
	int   done_cnt = 0;

	functional_unit functional_unit_i (
		.clk          ( clk          ),
		.rst_n        ( rst_n        ),
		.start        ( start        ),
		.num_steps    ( num_steps    ),
		.maxpool_mode ( maxpool_mode ),
		.in_valid     ( in_valid     ),
		.ifm_data     ( ifm_data     ),
		.wgt_data     ( wgt_data     ),
		.done         ( done         ),
		.busy         ( busy         ),
		.ofm_valid    ( ofm_valid    ),
		.ofm_data     ( ofm_data     )
	);

	always #10 clk = ~clk;

	task report_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	// values in -15..15
	function int small_value();
		return $random(seed) % 16;
	endfunction

	// values in 1..15
	function int positive_value();
		return 1 + ($unsigned($random(seed)) % 15);
	endfunction

	// with split_sign the upper ifm lanes are negative, so those rows sum below zero
	task fill_operands(input int steps, input bit split_sign);
		for (int s = 0; s < steps; s++) begin
			for (int i = 0; i < N; i++) begin
				if (split_sign) begin
					ifm_s[s][i] = (i < N / 2) ? positive_value() : -positive_value();
					wgt_s[s][i] = positive_value();
				end else begin
					ifm_s[s][i] = small_value();
					wgt_s[s][i] = small_value();
				end
			end
		end
	endtask

	task push_expected(input int steps, input bit pool);
		lane_t sums [N][N];
		lane_t best;
		vec_t  row;
		int    acc;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				acc = 0;
				for (int s = 0; s < steps; s++) begin
					acc += ifm_s[s][r] * wgt_s[s][c];
				end
				// keep the low 16 bits as a signed lane
				sums[r][c] = lane_t'(acc);
			end
		end
		if (!pool) begin
			for (int r = 0; r < N; r++) begin
				for (int c = 0; c < N; c++) begin
					row[c] = (sums[r][c] < 0) ? lane_t'(0) : sums[r][c];
				end
				exp_q.push_back(row);
			end
		end else begin
			for (int p = 0; p < N / 2; p++) begin
				row = '0;
				for (int j = 0; j < N / 2; j++) begin
					best = sums[2*p][2*j];
					if (sums[2*p][2*j+1] > best) best = sums[2*p][2*j+1];
					if (sums[2*p+1][2*j] > best) best = sums[2*p+1][2*j];
					if (sums[2*p+1][2*j+1] > best) best = sums[2*p+1][2*j+1];
					row[j] = (best < 0) ? lane_t'(0) : best;
				end
				exp_q.push_back(row);
			end
		end
	endtask

	task drive_beat(input int s);
		for (int i = 0; i < N; i++) begin
			ifm_data[i] = lane_t'(ifm_s[s][i]);
			wgt_data[i] = lane_t'(wgt_s[s][i]);
		end
	endtask

	// junk data that must never reach the FIFOs
	task drive_noise();
		for (int i = 0; i < N; i++) begin
			ifm_data[i] = lane_t'($random(seed));
			wgt_data[i] = lane_t'($random(seed));
		end
	endtask

	task wait_for_done(input int prev);
		int waited;
		waited = 0;
		while (done_cnt == prev && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (done_cnt == prev) begin
			report_error("timed out waiting for done");
		end
	endtask

	task run_case(input int steps, input bit pool, input bit split_sign);
		int prev;
		fill_operands(steps, split_sign);
		push_expected(steps, pool);
		prev = done_cnt;
		@(posedge clk);
		#2;
		start        = 1'b1;
		num_steps    = `FU_STEP_W'(steps);
		maxpool_mode = pool;
		@(posedge clk);
		#2;
		start = 1'b0;
		for (int s = 0; s < steps; s++) begin
			if (s > 0) begin
				@(posedge clk);
				#2;
			end
			in_valid = 1'b1;
			drive_beat(s);
		end
		// two stray beats land in COMPUTE and must be ignored
		repeat (2) begin
			@(posedge clk);
			#2;
			drive_noise();
		end
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		wait_for_done(prev);
	endtask

	always @(posedge clk) begin
		if (rst_n && ofm_valid) begin
			a_beat_expected: assert (exp_q.size() != 0)
				else report_error("ofm_valid beat with no result expected");
			a_beat_value: assert (ofm_data === exp_q[0])
				else report_error($sformatf("ofm_data %h, expected %h", ofm_data, exp_q[0]));
			void'(exp_q.pop_front());
		end
		if (rst_n && done) begin
			done_cnt++;
			a_done_after_beats: assert (exp_q.size() == 0)
				else report_error("done came before all output rows were seen");
		end
	end

	a_quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> (!done && !ofm_valid))
		else report_error("done or ofm_valid while the unit is idle");

	a_stays_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(!busy && !start) |=> !busy)
		else report_error("busy rose without start");

	a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else report_error("done lasted more than one cycle");

	initial begin
		rst_n        = 1'b0;
		start        = 1'b0;
		num_steps    = '0;
		maxpool_mode = 1'b0;
		in_valid     = 1'b0;
		ifm_data     = '0;
		wgt_data     = '0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// in_valid while idle must not start anything
		in_valid = 1'b1;
		drive_noise();
		repeat (3) @(posedge clk);
		#2;
		in_valid = 1'b0;
		@(negedge clk);
		a_idle_after_reset: assert (!busy && !done && !ofm_valid)
			else report_error("unit not idle after reset");

		run_case(4, 1'b0, 1'b0);
		run_case(5, 1'b0, 1'b1);
		run_case(6, 1'b1, 1'b0);
		run_case(3, 1'b1, 1'b1);
		run_case(1, 1'b0, 1'b0);
		run_case(MAX, 1'b0, 1'b0);
		run_case(1, 1'b1, 1'b0);
		run_case(MAX, 1'b1, 1'b0);
		run_case(MAX, 1'b0, 1'b1);

		repeat (4) @(posedge clk);
		if (exp_q.size() != 0) begin
			$display("expected output rows were never produced");
			$display("TB FAILED");
			$fatal(1, "missing output rows");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
src/fu_pkg.sv
src/fifo_ctrl_if.sv
src/skew_fifo_array.sv
src/pe_array.sv
src/ofm_output_stage.sv
src/fu_controller.sv
src/functional_unit.sv
test/tb_functional_unit.sv
